// File: filelist.f
common/cpu_pkg.sv
rtl/prog_mem.sv
rtl/fetch_unit.sv
rtl/instr_queue.sv
execute/alu.sv
execute/exec_unit.sv
rtl/cpu_top.sv
verif/cpu_chk.sv
verif/tb_cpu.sv

// File: Makefile
# Verilator build and run for the accumulator CPU testbench
# Any variable can be overridden on the command line, e.g. make run TOP=tb_cpu

VERILATOR ?= verilator
TOP       ?= tb_cpu
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?=

SRCS := $(wildcard common/*.sv rtl/*.sv execute/*.sv verif/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# Exit status of the binary is the pass or fail result
run: $(BIN)
	./$(BIN) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
  import cpu_pkg::*;

  localparam int NUM_DIRECTED   = 6;
  localparam int NUM_RANDOM     = 8;
  localparam int NUM_PROGS      = NUM_DIRECTED + NUM_RANDOM;
  // Up to 16 load cycles per program plus room for the run
  localparam int TIMEOUT_CYCLES = NUM_PROGS * (16 + 40);
  localparam int DRIVE_DLY      = 10;

  //////////////////////////////////////////////////
  // Directed programs
  //////////////////////////////////////////////////
  // Each word holds opcode, register and immediate
  // Program 0 is LDI 7F, ADDI 01, ADDI 90, HALT and overflows into carry
  // Program 1 subtracts a larger register value and borrows
  // Program 2 round-trips values through STR, LDR, ADD and SUB
  // Program 3 sets carry with ADDI and keeps it through OR, AND and XOR
  // Program 4 fills all 16 words and leaves r5 = 11 with carry set
  // Program 5 reloads words 0 to 3 and reuses words 4 and 5 of program 4
  localparam instr_word_t DIR_WORDS [NUM_DIRECTED][16] = '{
    '{16'h107F, 16'h5001, 16'h5090, 16'hF000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
      16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h1030, 16'h3200, 16'h1010, 16'h6200, 16'hF000, 16'h0000, 16'h0000, 16'h0000,
      16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h1025, 16'h3300, 16'h105A, 16'h3700, 16'h1000, 16'h2300, 16'h4700, 16'h3900,
      16'h1001, 16'h2900, 16'h6300, 16'hF000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h100F, 16'h3100, 16'h103C, 16'h3200, 16'h10A5, 16'h3400, 16'h10C8, 16'h5050,
      16'h8200, 16'h7100, 16'h9400, 16'hF000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h1011, 16'h3500, 16'h10F0, 16'h5020, 16'h8500, 16'hF000, 16'h0000, 16'h0000,
      16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h0000, 16'h0000, 16'h1040, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
      16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
  };
  localparam int    DIR_LEN   [NUM_DIRECTED] = '{4, 5, 12, 12, 16, 4};
  localparam data_t DIR_ACC   [NUM_DIRECTED] = '{8'h10, 8'hE0, 8'h5A, 8'hA9, 8'h11, 8'h40};
  localparam logic  DIR_CARRY [NUM_DIRECTED] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};

  // DUT signals
  logic        clk;
  logic        rstn;
  logic        load_en;
  pc_t         load_addr;
  instr_word_t load_data;
  logic        start;
  data_t       acc;
  logic        carry;
  logic        busy;
  logic        halted;

  // Full table with directed entries first and random ones after
  instr_word_t prog_words [NUM_PROGS][16];
  int          prog_len   [NUM_PROGS];
  data_t       exp_acc    [NUM_PROGS];
  logic        exp_carry  [NUM_PROGS];

  logic [31:0] rng_state   = 32'h8bf7b9fd;
  int          cycle_count = 0;

  cpu_top uut (
    .clk       (clk),
    .rstn      (rstn),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .start     (start),
    .acc       (acc),
    .carry     (carry),
    .busy      (busy),
    .halted    (halted)
  );

  // Queue assertions
  bind instr_queue cpu_chk #(.DEPTH(DEPTH)) u_chk (
    .clk        (clk),
    .rstn       (rstn),
    .start      (start),
    .push_uop   (push_uop),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .pop_uop    (pop_uop),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .count      (count)
  );

  // 100 ns clock
  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Watchdog
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $fatal(1, "Simulation stopped by the watchdog");
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected)
    begin
      $display("ERR %0t: %s got 0x%0h expected 0x%0h", $time, what, got, expected);
      $display("** FAIL **");
      $fatal(1, "Value mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  // Runs from address 0 with cleared state until HALT
  task automatic run_model(input int p, output data_t m_acc, output logic m_carry);
    data_t      m_regs [16];
    logic [3:0] op;
    logic [3:0] r;
    data_t      imm;
    logic [8:0] wide;
    int         pc;
    bit         done;
    m_acc   = '0;
    m_carry = 1'b0;
    pc      = 0;
    done    = 1'b0;
    for (int i = 0; i < 16; i++)
    begin
      m_regs[i] = '0;
    end
    while (!done && pc < 16)
    begin
      op  = prog_words[p][pc][15:12];
      r   = prog_words[p][pc][11:8];
      imm = prog_words[p][pc][7:0];
      case (op)
        OP_LDI:  m_acc = imm;
        OP_LDR:  m_acc = m_regs[r];
        OP_STR:  m_regs[r] = m_acc;
        OP_ADD, OP_ADDI:
        begin
          wide    = {1'b0, m_acc} + {1'b0, (op == OP_ADDI) ? imm : m_regs[r]};
          m_acc   = wide[7:0];
          m_carry = wide[8];
        end
        OP_SUB:
        begin
          // Borrow when the accumulator is the smaller value
          m_carry = (m_acc < m_regs[r]);
          m_acc   = m_acc - m_regs[r];
        end
        OP_AND:  m_acc = m_acc & m_regs[r];
        OP_OR:   m_acc = m_acc | m_regs[r];
        OP_XOR:  m_acc = m_acc ^ m_regs[r];
        OP_HALT: done = 1'b1;
        default: m_acc = m_acc;
      endcase
      pc++;
    end
  endtask

  task automatic build_table();
    logic [3:0] op;
    data_t      m_acc;
    logic       m_carry;
    for (int p = 0; p < NUM_DIRECTED; p++)
    begin
      prog_words[p] = DIR_WORDS[p];
      prog_len[p]   = DIR_LEN[p];
      exp_acc[p]    = DIR_ACC[p];
      exp_carry[p]  = DIR_CARRY[p];
    end
    // Random straight-line programs of 15 ops and a closing HALT
    for (int p = NUM_DIRECTED; p < NUM_PROGS; p++)
    begin
      for (int a = 0; a < 15; a++)
      begin
        rng_state = lcg_step(rng_state);
        // Codes 0 to 14 where the unused ones act as NOP
        op = 4'(rng_state[31:24] % 8'd15);
        prog_words[p][a] = {op, rng_state[23:20], rng_state[19:12]};
      end
      prog_words[p][15] = {OP_HALT, 12'h000};
      prog_len[p] = 16;
      run_model(p, m_acc, m_carry);
      exp_acc[p]   = m_acc;
      exp_carry[p] = m_carry;
    end
  endtask

  // One word per cycle through the loading port
  task automatic load_program(input int p);
    for (int a = 0; a < prog_len[p]; a++)
    begin
      @(posedge clk);
      #DRIVE_DLY;
      load_en   = 1'b1;
      load_addr = pc_t'(a);
      load_data = prog_words[p][a];
    end
    @(posedge clk);
    #DRIVE_DLY;
    load_en = 1'b0;
  endtask

  // Pulse start and wait for halted while busy stays high
  task automatic run_program(input int p);
    start = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    start = 1'b0;
    while (halted !== 1'b1)
    begin
      check_value(busy, 1, $sformatf("program %0d busy before halt", p));
      @(posedge clk);
      #DRIVE_DLY;
    end
    check_value(busy, 0, $sformatf("program %0d busy after halt", p));
    check_value(acc, exp_acc[p], $sformatf("program %0d acc", p));
    check_value(carry, exp_carry[p], $sformatf("program %0d carry", p));
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial
  begin
    rstn      = 1'b0;
    start     = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    build_table();
    repeat (16) @(posedge clk);
    #DRIVE_DLY;
    // Idle state out of reset
    check_value(busy, 0, "busy after reset");
    check_value(halted, 0, "halted after reset");
    check_value(carry, 0, "carry after reset");
    check_value(acc, 0, "acc after reset");
    rstn = 1'b1;
    for (int p = 0; p < NUM_PROGS; p++)
    begin
      load_program(p);
      run_program(p);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// File: verif/cpu_chk.sv
`timescale 1ns/1ps

module cpu_chk #(
  parameter int DEPTH = cpu_pkg::QUEUE_DEPTH
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  start,
  input  cpu_pkg::uop_t         push_uop,
  input  logic                  push_valid,
  input  logic                  push_ready,
  input  cpu_pkg::uop_t         pop_uop,
  input  logic                  pop_valid,
  input  logic                  pop_ready,
  input  logic [$clog2(DEPTH):0] count
);

  localparam int CNT_W = $clog2(DEPTH) + 1;

  logic             push_fire;
  logic             pop_fire;
  // Occupancy rebuilt from the handshakes alone
  logic [CNT_W-1:0] occ;

  assign push_fire = push_valid && push_ready;
  assign pop_fire  = pop_valid && pop_ready;

  // Start empties the queue just like reset
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      occ <= '0;
    end
    else if (start)
    begin
      occ <= '0;
    end
    else
    begin
      occ <= occ + CNT_W'(push_fire) - CNT_W'(pop_fire);
    end
  end

  //////////////////////////////////////////////////
  // Occupancy
  //////////////////////////////////////////////////

  // Accepted push needs a free slot
  a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
    push_fire |-> (occ < DEPTH))
    else $error("queue accepted a push while full");

  // Accepted pop needs an item
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn)
    pop_fire |-> (occ != '0))
    else $error("queue accepted a pop while empty");

  a_count_range: assert property (@(posedge clk) disable iff (!rstn)
    count <= DEPTH)
    else $error("queue count above depth");

  //////////////////////////////////////////////////
  // Handshake stability
  //////////////////////////////////////////////////

  // Stalled push keeps its uop
  a_push_hold: assert property (@(posedge clk) disable iff (!rstn)
    (push_valid && !push_ready) |=> (push_valid && $stable(push_uop)))
    else $error("push valid dropped or uop changed while stalled");

  a_pop_hold: assert property (@(posedge clk) disable iff (!rstn)
    (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_uop)))
    else $error("pop valid dropped or uop changed while stalled");

endmodule

// File: rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
  input  logic                 clk,
  input  logic                 rstn,
  // Program loading port
  input  logic                 load_en,
  input  cpu_pkg::pc_t         load_addr,
  input  cpu_pkg::instr_word_t load_data,
  // Run control and status
  input  logic                 start,
  output cpu_pkg::data_t       acc,
  output logic                 carry,
  output logic                 busy,
  output logic                 halted
);
  import cpu_pkg::*;

  // Memory to fetch
  pc_t         fetch_addr;
  instr_word_t fetch_word;
  // Fetch to queue
  uop_t        push_uop;
  logic        push_valid;
  logic        push_ready;
  // Queue to execute
  uop_t        pop_uop;
  logic        pop_valid;
  logic        pop_ready;
  // Execute back to fetch
  logic        retire_halt;

  //////////////////////////////////////////////////
  // Pipeline: memory, fetch, queue, execute
  //////////////////////////////////////////////////
  prog_mem u_prog_mem (
    .clk        (clk),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .fetch_addr (fetch_addr),
    .fetch_word (fetch_word)
  );

  fetch_unit u_fetch (
    .clk         (clk),
    .rstn        (rstn),
    .start       (start),
    .retire_halt (retire_halt),
    .fetch_addr  (fetch_addr),
    .fetch_word  (fetch_word),
    .push_uop    (push_uop),
    .push_valid  (push_valid),
    .push_ready  (push_ready),
    .busy        (busy)
  );

  instr_queue #(
    .DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk        (clk),
    .rstn       (rstn),
    .start      (start),
    .push_uop   (push_uop),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .pop_uop    (pop_uop),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready)
  );

  exec_unit u_exec (
    .clk         (clk),
    .rstn        (rstn),
    .start       (start),
    .pop_uop     (pop_uop),
    .pop_valid   (pop_valid),
    .pop_ready   (pop_ready),
    .acc         (acc),
    .carry       (carry),
    .halted      (halted),
    .retire_halt (retire_halt)
  );

endmodule

// File: execute/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  logic           clk,
  input  logic           rstn,
  input  logic           start,
  // Pop side of the instruction queue
  input  cpu_pkg::uop_t  pop_uop,
  input  logic           pop_valid,
  output logic           pop_ready,
  // Architectural state
  output cpu_pkg::data_t acc,
  output logic           carry,
  output logic           halted,
  // Pulse back to fetch when HALT retires
  output logic           retire_halt
);
  import cpu_pkg::*;

  data_t regs [NUM_REGS];
  logic  pop_fire;
  logic  use_imm;
  data_t operand;
  data_t alu_result;
  logic  alu_carry;

  //////////////////////////////////////////////////
  // Issue
  //////////////////////////////////////////////////

  // Take one uop per cycle until halted
  assign pop_ready = !halted;
  assign pop_fire  = pop_valid && pop_ready;

  // Immediate forms use imm, everything else reads the register
  assign use_imm = (pop_uop.op == OP_ADDI) || (pop_uop.op == OP_LDI);
  assign operand = use_imm ? pop_uop.imm : regs[pop_uop.reg_idx];

  alu u_alu (
    .op        (pop_uop.op),
    .a         (acc),
    .b         (operand),
    .carry_in  (carry),
    .result    (alu_result),
    .carry_out (alu_carry)
  );

  assign retire_halt = pop_fire && (pop_uop.op == OP_HALT);

  //////////////////////////////////////////////////
  // Retire
  //////////////////////////////////////////////////

  // Accumulator, carry and halted flag
  // NOP, STR and HALT come back from the ALU unchanged
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      acc    <= '0;
      carry  <= 1'b0;
      halted <= 1'b0;
    end
    else if (start)
    begin
      acc    <= '0;
      carry  <= 1'b0;
      halted <= 1'b0;
    end
    else if (pop_fire)
    begin
      acc   <= alu_result;
      carry <= alu_carry;
      if (pop_uop.op == OP_HALT)
      begin
        halted <= 1'b1;
      end
    end
  end

  // Register file, cleared on start, written by STR
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (pop_fire && (pop_uop.op == OP_STR))
    begin
      regs[pop_uop.reg_idx] <= acc;
    end
  end

endmodule

// File: execute/alu.sv
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::opcode_e op,
  // a is the accumulator, b the register or immediate operand
  input  cpu_pkg::data_t   a,
  input  cpu_pkg::data_t   b,
  input  logic             carry_in,
  output cpu_pkg::data_t   result,
  output logic             carry_out
);
  import cpu_pkg::*;

  // Nine bit results, top bit is carry or borrow
  logic [8:0] sum;
  logic [8:0] diff;

  assign sum  = {1'b0, a} + {1'b0, b};
  // Wraps negative when a < b, so bit 8 is the borrow
  assign diff = {1'b0, a} - {1'b0, b};

  always_comb
  begin
    // Hold accumulator and carry by default
    result    = a;
    carry_out = carry_in;
    case (op)
      OP_ADD, OP_ADDI:
        {carry_out, result} = sum;
      OP_SUB:
        {carry_out, result} = diff;
      // Logic ops leave the carry as it was
      OP_AND:
        result = a & b;
      OP_OR:
        result = a | b;
      OP_XOR:
        result = a ^ b;
      // Loads
      OP_LDI, OP_LDR:
        result = b;
      default:
        result = a;
    endcase
  end

endmodule

// File: rtl/instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(
  parameter int DEPTH = cpu_pkg::QUEUE_DEPTH
) (
  input  logic          clk,
  input  logic          rstn,
  input  logic          start,
  // Push side, from fetch
  input  cpu_pkg::uop_t push_uop,
  input  logic          push_valid,
  output logic          push_ready,
  // Pop side, to execute
  output cpu_pkg::uop_t pop_uop,
  output logic          pop_valid,
  input  logic          pop_ready
);
  import cpu_pkg::*;

  // DEPTH is a power of two so the pointers wrap on their own
  localparam int PTR_W = $clog2(DEPTH);

  uop_t             mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  // One bit wider than the pointers to reach DEPTH
  logic [PTR_W:0]   count;
  logic             push_fire;
  logic             pop_fire;

  // Flags
  assign push_ready = (count != (PTR_W + 1)'(DEPTH));
  assign pop_valid  = (count != '0);
  assign push_fire  = push_valid && push_ready;
  assign pop_fire   = pop_valid && pop_ready;

  // Head of the queue
  assign pop_uop = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk)
  begin
    if (push_fire)
    begin
      mem[wr_ptr] <= push_uop;
    end
  end

  // Pointers and count
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else if (start)
    begin
      // Drop whatever an earlier run left behind
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_fire)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_fire)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 start,
  input  logic                 retire_halt,
  // Program memory
  output cpu_pkg::pc_t         fetch_addr,
  input  cpu_pkg::instr_word_t fetch_word,
  // Push side of the instruction queue
  output cpu_pkg::uop_t        push_uop,
  output logic                 push_valid,
  input  logic                 push_ready,
  output logic                 busy
);
  import cpu_pkg::*;

  fetch_state_e state;
  pc_t          pc;
  // Memory output holds the word at pc
  logic         word_valid;
  logic         push_fire;
  logic         is_halt;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  always_comb
  begin
    push_uop.reg_idx = fetch_word[11:8];
    push_uop.imm     = fetch_word[7:0];
    case (fetch_word[15:12])
      OP_LDI, OP_LDR, OP_STR, OP_ADD, OP_ADDI, OP_SUB,
      OP_AND, OP_OR, OP_XOR, OP_HALT:
        push_uop.op = opcode_e'(fetch_word[15:12]);
      // Unused codes run as NOP
      default:
        push_uop.op = OP_NOP;
    endcase
  end

  assign is_halt    = (push_uop.op == OP_HALT);
  assign push_valid = (state == FETCH_RUN) && word_valid;
  assign push_fire  = push_valid && push_ready;

  // Look one address ahead on an accepted push so the next word lands in time
  // A stall keeps re-reading the same address
  assign fetch_addr = push_fire ? pc + pc_t'(1) : pc;

  assign busy = (state != FETCH_IDLE);

  //////////////////////////////////////////////////
  // State machine and PC
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state      <= FETCH_IDLE;
      pc         <= '0;
      word_valid <= 1'b0;
    end
    else
    begin
      case (state)
        FETCH_IDLE:
        begin
          word_valid <= 1'b0;
          if (start)
          begin
            state <= FETCH_RUN;
            pc    <= '0;
          end
        end
        FETCH_RUN:
        begin
          // First RUN cycle reads address 0, data valid from then on
          word_valid <= 1'b1;
          if (push_fire)
          begin
            pc <= pc + pc_t'(1);
            // HALT ends fetching
            if (is_halt)
            begin
              state      <= FETCH_DONE;
              word_valid <= 1'b0;
            end
          end
        end
        FETCH_DONE:
        begin
          // Wait for execute to retire the HALT
          if (retire_halt)
          begin
            state <= FETCH_IDLE;
          end
        end
        default:
        begin
          state <= FETCH_IDLE;
        end
      endcase
    end
  end

endmodule

// File: rtl/prog_mem.sv
`timescale 1ns/1ps

module prog_mem (
  input  logic                 clk,
  // Loading port
  input  logic                 load_en,
  input  cpu_pkg::pc_t         load_addr,
  input  cpu_pkg::instr_word_t load_data,
  // Fetch side read port
  input  cpu_pkg::pc_t         fetch_addr,
  output cpu_pkg::instr_word_t fetch_word
);
  import cpu_pkg::*;

  // Program storage, keeps its contents from one run to the next
  instr_word_t mem [PROG_DEPTH];

  // Write from the loading port
  always_ff @(posedge clk)
  begin
    if (load_en)
    begin
      mem[load_addr] <= load_data;
    end
  end

  // Registered read
  // Word for fetch_addr shows up one cycle later
  always_ff @(posedge clk)
  begin
    fetch_word <= mem[fetch_addr];
  end

endmodule

// File: common/cpu_pkg.sv
package cpu_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Accumulator, register and immediate value
  typedef logic [7:0]  data_t;
  // Program memory address
  typedef logic [3:0]  pc_t;
  // Register file index
  typedef logic [3:0]  reg_addr_t;
  // Raw instruction: opcode [15:12], register [11:8], immediate [7:0]
  typedef logic [15:0] instr_word_t;

  // Depths
  localparam int PROG_DEPTH  = 16;
  localparam int NUM_REGS    = 16;
  localparam int QUEUE_DEPTH = 4;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Operation codes, anything not listed decodes to NOP
  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_LDI  = 4'h1,
    OP_LDR  = 4'h2,
    OP_STR  = 4'h3,
    OP_ADD  = 4'h4,
    OP_ADDI = 4'h5,
    OP_SUB  = 4'h6,
    OP_AND  = 4'h7,
    OP_OR   = 4'h8,
    OP_XOR  = 4'h9,
    OP_HALT = 4'hf
  } opcode_e;

  // Fetch side state machine
  typedef enum logic [1:0] {
    FETCH_IDLE = 2'b00,
    FETCH_RUN  = 2'b01,
    FETCH_DONE = 2'b10
  } fetch_state_e;

  // One decoded instruction, same field order as the raw word
  typedef struct packed {
    opcode_e   op;
    reg_addr_t reg_idx;
    data_t     imm;
  } uop_t;

endpackage
